// File: compile.f
common/fetch_pkg.sv
fetch/pc_unit.sv
fetch/if_stage.sv
src/fetch_queue.sv
src/fetch_top.sv
tests/imem_model.sv
tests/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_subsystem

sources:
  - files:
      - common/fetch_pkg.sv
      - fetch/pc_unit.sv
      - fetch/if_stage.sv
      - src/fetch_queue.sv
      - src/fetch_top.sv
  - target: test
    files:
      - tests/imem_model.sv
      - tests/fetch_tb.sv

// File: tests/fetch_tb.sv
// queue depth fixed at 4; branch targets kept apart so the two threads never share a word
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

	localparam int          PERIOD       = 100;
	localparam int          RESET_CYCLES = 4;
	localparam int          DRAIN_CYCLES = 40;
	localparam int          DEPTH        = 4;
	localparam int unsigned SEED         = 32'h8c010ce5;
	localparam addr_t       START_PC1    = 64'h1000;
	localparam addr_t       START_PC2    = 64'h8004;

	typedef struct packed {
		logic        two_threads;
		logic        br1;
		addr_t       tgt1;
		logic        br2;
		addr_t       tgt2;
		logic        rob1;
		logic        rob2;
		logic        rs;
		logic        rat;
		logic        ready;
		logic [15:0] hold;      // cycles the row stays applied
	} row_t;

	typedef struct packed {
		thread_t thread;
		addr_t   pc;
		inst_t   inst0;
		inst_t   inst1;
		logic    v0;
		logic    v1;
	} entry_t;

	logic    clock = 1'b0;
	logic    reset;
	logic    two_threads;
	logic    branch_taken1;
	logic    branch_taken2;
	addr_t   target_pc1;
	addr_t   target_pc2;
	logic    rob_stall1;
	logic    rob_stall2;
	logic    rs_stall;
	logic    rat_stall;
	logic    out_ready;
	addr_t   imem_addr;
	word_t   imem_data;
	logic    imem_valid;
	logic    out_valid;
	thread_t out_thread;
	addr_t   out_pc;
	inst_t   out_inst0;
	inst_t   out_inst1;
	logic    out_inst0_valid;
	logic    out_inst1_valid;

	// reference model state
	addr_t   m_pc1;
	addr_t   m_pc2;
	logic    m_sel;             // 0 picks thread 1
	entry_t  exp_q[$];
	row_t    tbl[$];

	int      value_errors   = 0;
	int      missing_errors = 0;
	int      extra_errors   = 0;
	int      timeout_cycles = 0;
	logic    table_ready    = 1'b0;

	always #(PERIOD / 2) clock = ~clock;

	fetch_top #(
		.RESET_PC1   (START_PC1),
		.RESET_PC2   (START_PC2),
		.QUEUE_DEPTH (DEPTH)
	) i_dut (
		.clock, .reset, .two_threads,
		.branch_taken1, .branch_taken2, .target_pc1, .target_pc2,
		.rob_stall1, .rob_stall2, .rs_stall, .rat_stall,
		.imem_addr, .imem_data, .imem_valid,
		.out_ready, .out_valid, .out_thread, .out_pc,
		.out_inst0, .out_inst1, .out_inst0_valid, .out_inst1_valid
	);

	imem_model #(.SEED (SEED)) i_imem (.clock, .reset, .imem_addr, .imem_data, .imem_valid);

	//////////////////////////////
	// helpers
	//////////////////////////////

	function automatic addr_t word_of(addr_t a);
		return {a[63:3], 3'b000};
	endfunction

	function automatic inst_t low_inst(addr_t a);
		return a[31:0] ^ a[63:32];  // memory fill rule
	endfunction

	task automatic check_addr(string what, addr_t got, addr_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_inst(string what, inst_t got, inst_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_thread(string what, thread_t got, thread_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(string what, logic got, logic exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic add_row(logic tt, logic b1, addr_t t1, logic b2, addr_t t2,
		logic r1, logic r2, logic rs, logic rat, logic rdy, int hold);
		row_t r;
		r = '{tt, b1, t1, b2, t2, r1, r2, rs, rat, rdy, 16'(hold)};
		tbl.push_back(r);
	endtask

	//////////////////////////////
	// reference model and checks
	//////////////////////////////

	always @(negedge clock)
	begin : model
		logic   sel;
		addr_t  cur_pc;
		int     occ;
		logic   pop_pred;
		logic   full_pred;
		logic   accept;
		entry_t e;
		if (reset)
		begin
			m_pc1 = START_PC1;
			m_pc2 = START_PC2;
			m_sel = 1'b0;
			exp_q.delete();
		end
		else
		begin
			sel    = two_threads ? m_sel : 1'b0;
			cur_pc = sel ? m_pc2 : m_pc1;
			occ    = exp_q.size();
			check_addr("imem_addr", imem_addr, word_of(cur_pc));
			check_flag("out_valid", out_valid, occ != 0);

			// entry leaving towards decode
			if (out_valid && out_ready)
			begin
				if (occ == 0)
				begin
					extra_errors++;
					$display("unexpected extra entry at the queue head at %0t ns", $time);
				end
				else
				begin
					e = exp_q.pop_front();
					check_thread("out_thread", out_thread, e.thread);
					check_addr("out_pc", out_pc, e.pc);
					check_inst("out_inst0", out_inst0, e.inst0);
					check_inst("out_inst1", out_inst1, e.inst1);
					check_flag("out_inst0_valid", out_inst0_valid, e.v0);
					check_flag("out_inst1_valid", out_inst1_valid, e.v1);
				end
			end

			// acceptance at the memory port for the coming edge
			pop_pred  = (occ != 0) && out_ready;
			full_pred = (occ == DEPTH) && !pop_pred;
			accept    = imem_valid && !(sel ? rob_stall2 : rob_stall1) && !rs_stall
				&& !rat_stall && !full_pred && !(sel ? branch_taken2 : branch_taken1);
			if (accept)
			begin
				e.thread = thread_t'(sel);
				e.pc     = word_of(cur_pc);
				e.inst0  = low_inst(e.pc);
				e.inst1  = low_inst(e.pc) + 32'd4;
				e.v0     = ~cur_pc[2];
				e.v1     = 1'b1;
				exp_q.push_back(e);
			end

			// pc and selector for the coming edge
			if (branch_taken1)
				m_pc1 = target_pc1;
			else if (accept && !sel)
				m_pc1 = word_of(m_pc1) + 64'd8;
			if (branch_taken2)
				m_pc2 = target_pc2;
			else if (accept && sel)
				m_pc2 = word_of(m_pc2) + 64'd8;
			if (!two_threads)
				m_sel = 1'b0;
			else if (accept)
				m_sel = ~m_sel;
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial
	begin
		int total;
		int k;
		reset         = 1'b1;
		two_threads   = 1'b0;
		branch_taken1 = 1'b0;
		branch_taken2 = 1'b0;
		target_pc1    = '0;
		target_pc2    = '0;
		rob_stall1    = 1'b0;
		rob_stall2    = 1'b0;
		rs_stall      = 1'b0;
		rat_stall     = 1'b0;
		out_ready     = 1'b0;

		// tt  br1 tgt1      br2 tgt2      rob1 rob2 rs rat rdy hold
		add_row(0, 0, 64'h0,    0, 64'h0,    0, 0, 0, 0, 1, 30);  // thread 1 alone
		add_row(1, 0, 64'h0,    0, 64'h0,    0, 0, 0, 0, 1, 40);
		add_row(1, 1, 64'h2004, 0, 64'h0,    0, 0, 0, 0, 1, 1);   // unaligned redirect
		add_row(1, 0, 64'h0,    0, 64'h0,    0, 0, 0, 0, 1, 30);
		add_row(1, 0, 64'h0,    1, 64'h9004, 0, 0, 0, 0, 1, 1);
		add_row(1, 0, 64'h0,    0, 64'h0,    0, 0, 0, 0, 1, 30);
		add_row(1, 0, 64'h0,    0, 64'h0,    1, 0, 0, 0, 1, 25);  // rob full, thread 1
		add_row(1, 0, 64'h0,    0, 64'h0,    0, 0, 1, 0, 1, 10);
		add_row(1, 0, 64'h0,    0, 64'h0,    0, 0, 0, 1, 1, 10);
		add_row(1, 0, 64'h0,    0, 64'h0,    0, 0, 0, 0, 0, 20);  // decode blocked
		add_row(1, 0, 64'h0,    0, 64'h0,    0, 0, 0, 0, 1, 30);
		add_row(0, 0, 64'h0,    0, 64'h0,    0, 0, 0, 0, 0, 10);
		add_row(0, 0, 64'h0,    0, 64'h0,    0, 0, 0, 0, 1, 30);
		add_row(1, 0, 64'h0,    0, 64'h0,    0, 1, 0, 0, 1, 20);  // rob full, thread 2

		total = RESET_CYCLES + DRAIN_CYCLES;
		foreach (tbl[i])
			total += tbl[i].hold;
		timeout_cycles = total * 4;
		table_ready    = 1'b1;

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		foreach (tbl[i])
		begin
			two_threads   <= tbl[i].two_threads;
			branch_taken1 <= tbl[i].br1;
			target_pc1    <= tbl[i].tgt1;
			branch_taken2 <= tbl[i].br2;
			target_pc2    <= tbl[i].tgt2;
			rob_stall1    <= tbl[i].rob1;
			rob_stall2    <= tbl[i].rob2;
			rs_stall      <= tbl[i].rs;
			rat_stall     <= tbl[i].rat;
			out_ready     <= tbl[i].ready;
			repeat (tbl[i].hold) @(posedge clock);
		end

		// stop fetching and empty the queue
		rs_stall  <= 1'b1;
		out_ready <= 1'b1;
		for (k = 0; k < DRAIN_CYCLES && exp_q.size() != 0; k++)
			@(posedge clock);
		repeat (4) @(posedge clock);  // catch stray entries
		if (exp_q.size() != 0)
		begin
			missing_errors += exp_q.size();
			$display("%0d expected entries never left the queue", exp_q.size());
		end

		$display("errors: %0d wrong values, %0d missing entries, %0d extra entries",
			value_errors, missing_errors, extra_errors);
		if (value_errors + missing_errors + extra_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		wait (table_ready);
		repeat (timeout_cycles) @(posedge clock);
		$display("watchdog expired after %0d cycles, the run did not finish", timeout_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: tests/imem_model.sv
// instruction memory for simulation; words answer 1 to 4 cycles after the address changes
`timescale 1ns/1ps

module imem_model import fetch_pkg::*; #(
	parameter int unsigned SEED = 0
) (
	input  logic  clock,
	input  logic  reset,
	input  addr_t imem_addr,
	output word_t imem_data,
	output logic  imem_valid
);

	addr_t       last_addr;   // address the current wait belongs to
	logic [1:0]  wait_cnt;

	//////////////////////////////
	// address-derived contents
	//////////////////////////////

	// low half mixes both address halves, high half is the next instruction address
	assign imem_data[31:0]  = imem_addr[31:0] ^ imem_addr[63:32];
	assign imem_data[63:32] = imem_data[31:0] + 32'd4;

	assign imem_valid = !reset && (imem_addr == last_addr) && (wait_cnt == 2'd0);

	//////////////////////////////
	// response delay
	//////////////////////////////

	initial
	begin
		void'($urandom(SEED));  // one seed for the whole run
		last_addr  = '1;
		wait_cnt   = 2'd0;
		forever
		begin
			@(posedge clock);
			if (reset)
			begin
				last_addr <= '1;  // never a word address
				wait_cnt  <= 2'd0;
			end
			else if (imem_addr != last_addr)
			begin
				last_addr <= imem_addr;
				wait_cnt  <= 2'($urandom % 4);  // 0 to 3 extra cycles
			end
			else if (wait_cnt != 2'd0)
			begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end
	end

endmodule

// File: src/fetch_top.sv
// fetch subsystem top; memory answers on imem_valid, decode takes pairs with out_valid/out_ready
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
	parameter addr_t RESET_PC1   = 64'h0,
	parameter addr_t RESET_PC2   = 64'h0,
	parameter int    QUEUE_DEPTH = 4
) (
	input  logic    clock,
	input  logic    reset,
	input  logic    two_threads,

	// branch resolution
	input  logic    branch_taken1,
	input  logic    branch_taken2,
	input  addr_t   target_pc1,
	input  addr_t   target_pc2,

	// stalls from the back end
	input  logic    rob_stall1,
	input  logic    rob_stall2,
	input  logic    rs_stall,
	input  logic    rat_stall,

	// instruction memory
	output addr_t   imem_addr,
	input  word_t   imem_data,
	input  logic    imem_valid,

	// decode side
	input  logic    out_ready,
	output logic    out_valid,
	output thread_t out_thread,
	output addr_t   out_pc,
	output inst_t   out_inst0,
	output inst_t   out_inst1,
	output logic    out_inst0_valid,
	output logic    out_inst1_valid
);

	// fetch to queue
	logic    push;
	logic    full;
	thread_t push_thread;
	addr_t   push_pc;
	inst_t   push_inst0;
	inst_t   push_inst1;
	logic    push_inst0_valid;
	logic    push_inst1_valid;

	if_stage #(
		.RESET_PC1 (RESET_PC1),
		.RESET_PC2 (RESET_PC2)
	) i_if_stage (
		.clock            (clock),
		.reset            (reset),
		.two_threads      (two_threads),
		.branch_taken1    (branch_taken1),
		.branch_taken2    (branch_taken2),
		.target_pc1       (target_pc1),
		.target_pc2       (target_pc2),
		.rob_stall1       (rob_stall1),
		.rob_stall2       (rob_stall2),
		.rs_stall         (rs_stall),
		.rat_stall        (rat_stall),
		.imem_data        (imem_data),
		.imem_valid       (imem_valid),
		.imem_addr        (imem_addr),
		.full             (full),
		.push             (push),
		.push_thread      (push_thread),
		.push_pc          (push_pc),
		.push_inst0       (push_inst0),
		.push_inst1       (push_inst1),
		.push_inst0_valid (push_inst0_valid),
		.push_inst1_valid (push_inst1_valid)
	);

	fetch_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) i_fetch_queue (
		.clock            (clock),
		.reset            (reset),
		.push             (push),
		.push_thread      (push_thread),
		.push_pc          (push_pc),
		.push_inst0       (push_inst0),
		.push_inst1       (push_inst1),
		.push_inst0_valid (push_inst0_valid),
		.push_inst1_valid (push_inst1_valid),
		.full             (full),
		.out_ready        (out_ready),
		.out_valid        (out_valid),
		.out_thread       (out_thread),
		.out_pc           (out_pc),
		.out_inst0        (out_inst0),
		.out_inst1        (out_inst1),
		.out_inst0_valid  (out_inst0_valid),
		.out_inst1_valid  (out_inst1_valid)
	);

endmodule

// File: src/fetch_queue.sv
// circular FIFO of fetched pairs; full already counts a pop in the same edge, no flush
`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic    clock,
	input  logic    reset,

	// from fetch
	input  logic    push,
	input  thread_t push_thread,
	input  addr_t   push_pc,
	input  inst_t   push_inst0,
	input  inst_t   push_inst1,
	input  logic    push_inst0_valid,
	input  logic    push_inst1_valid,
	output logic    full,

	// to decode
	input  logic    out_ready,
	output logic    out_valid,
	output thread_t out_thread,
	output addr_t   out_pc,
	output inst_t   out_inst0,
	output inst_t   out_inst1,
	output logic    out_inst0_valid,
	output logic    out_inst1_valid
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	// entry storage, one array per field
	thread_t             thread_mem [QUEUE_DEPTH];
	addr_t               pc_mem     [QUEUE_DEPTH];
	inst_t               inst0_mem  [QUEUE_DEPTH];
	inst_t               inst1_mem  [QUEUE_DEPTH];
	logic [QUEUE_DEPTH-1:0] v0_mem;
	logic [QUEUE_DEPTH-1:0] v1_mem;

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign out_valid = (count != '0);
	assign do_pop    = out_valid && out_ready;

	// a leaving head frees a slot for this edge's push
	assign full    = (count == CNT_W'(QUEUE_DEPTH)) && !do_pop;
	assign do_push = push && !full;

	//////////////////////////////
	// pointers and count
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
			begin
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	//////////////////////////////
	// storage
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (do_push)
		begin
			thread_mem[wr_ptr] <= push_thread;
			pc_mem[wr_ptr]     <= push_pc;
			inst0_mem[wr_ptr]  <= push_inst0;
			inst1_mem[wr_ptr]  <= push_inst1;
			v0_mem[wr_ptr]     <= push_inst0_valid;
			v1_mem[wr_ptr]     <= push_inst1_valid;
		end
	end

	// head entry, meaningful only with out_valid
	assign out_thread      = thread_mem[rd_ptr];
	assign out_pc          = pc_mem[rd_ptr];
	assign out_inst0       = inst0_mem[rd_ptr];
	assign out_inst1       = inst1_mem[rd_ptr];
	assign out_inst0_valid = v0_mem[rd_ptr];
	assign out_inst1_valid = v1_mem[rd_ptr];

endmodule

// File: fetch/if_stage.sv
// memory must hold imem_data for the current imem_addr while imem_valid is high; no prediction
`timescale 1ns/1ps

module if_stage import fetch_pkg::*; #(
	parameter addr_t RESET_PC1 = '0,
	parameter addr_t RESET_PC2 = '0
) (
	input  logic    clock,
	input  logic    reset,
	input  logic    two_threads,       // low runs thread 1 alone

	// redirects from execute
	input  logic    branch_taken1,
	input  logic    branch_taken2,
	input  addr_t   target_pc1,
	input  addr_t   target_pc2,

	// back end stalls
	input  logic    rob_stall1,
	input  logic    rob_stall2,
	input  logic    rs_stall,
	input  logic    rat_stall,

	// instruction memory
	input  word_t   imem_data,
	input  logic    imem_valid,
	output addr_t   imem_addr,

	// to the fetch queue
	input  logic    full,
	output logic    push,
	output thread_t push_thread,
	output addr_t   push_pc,
	output inst_t   push_inst0,
	output inst_t   push_inst1,
	output logic    push_inst0_valid,
	output logic    push_inst1_valid
);

	thread_sel_t sel_q;       // registered selector
	thread_sel_t sel;         // thread owning this cycle's fetch
	addr_t       word_addr1;
	addr_t       word_addr2;
	logic        first_valid1;
	logic        first_valid2;
	logic        advance1;
	logic        advance2;
	logic        sel_rob_stall;
	logic        sel_redirect;
	logic        accept;

	//////////////////////////////
	// program counters
	//////////////////////////////

	pc_unit #(
		.RESET_PC (RESET_PC1)
	) i_pc1 (
		.clock            (clock),
		.reset            (reset),
		.branch_taken     (branch_taken1),
		.target_pc        (target_pc1),
		.advance          (advance1),
		.pc               (),
		.word_addr        (word_addr1),
		.first_slot_valid (first_valid1)
	);

	pc_unit #(
		.RESET_PC (RESET_PC2)
	) i_pc2 (
		.clock            (clock),
		.reset            (reset),
		.branch_taken     (branch_taken2),
		.target_pc        (target_pc2),
		.advance          (advance2),
		.pc               (),
		.word_addr        (word_addr2),
		.first_slot_valid (first_valid2)
	);

	//////////////////////////////
	// thread selector
	//////////////////////////////

	assign sel = two_threads ? sel_q : SEL_THREAD1;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			sel_q <= SEL_THREAD1;
		end
		else if (!two_threads)
		begin
			sel_q <= SEL_THREAD1;  // single thread parks on thread 1
		end
		else if (accept)
		begin
			sel_q <= (sel_q == SEL_THREAD1) ? SEL_THREAD2 : SEL_THREAD1;
		end
	end

	// steer the selected thread onto the memory port
	always_comb
	begin
		case (sel)
			SEL_THREAD2:
			begin
				imem_addr        = word_addr2;
				push_inst0_valid = first_valid2;
				sel_rob_stall    = rob_stall2;
				sel_redirect     = branch_taken2;
			end
			default:
			begin
				imem_addr        = word_addr1;
				push_inst0_valid = first_valid1;
				sel_rob_stall    = rob_stall1;
				sel_redirect     = branch_taken1;
			end
		endcase
	end

	//////////////////////////////
	// acceptance and push
	//////////////////////////////

	// a redirect of the selected thread throws this word away
	assign accept = imem_valid && !sel_rob_stall && !rs_stall && !rat_stall
		&& !full && !sel_redirect;

	assign advance1 = accept && (sel == SEL_THREAD1);
	assign advance2 = accept && (sel == SEL_THREAD2);

	assign push             = accept;
	assign push_thread      = thread_t'(sel);
	assign push_pc          = imem_addr;          // word address
	assign push_inst0       = imem_data[31:0];    // instruction at the word address
	assign push_inst1       = imem_data[63:32];   // word address plus 4
	assign push_inst1_valid = 1'b1;               // upper slot always in the stream

endmodule

// File: fetch/pc_unit.sv
// one thread's pc; a redirect beats an accepted fetch, targets may sit on the upper slot of a word
`timescale 1ns/1ps

module pc_unit import fetch_pkg::*; #(
	parameter addr_t RESET_PC = '0
) (
	input  logic  clock,
	input  logic  reset,

	// redirect from execute
	input  logic  branch_taken,
	input  addr_t target_pc,

	input  logic  advance,           // fetch for this thread accepted

	output addr_t pc,                // full pc, may point at the upper slot
	output addr_t word_addr,         // pc rounded down to the word
	output logic  first_slot_valid   // lower instruction belongs to the stream
);

	addr_t next_pc;
	addr_t seq_pc;

	//////////////////////////////
	// word alignment
	//////////////////////////////

	// drop the byte offset, memory only sees whole words
	assign word_addr = {pc[$bits(addr_t)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

	// pc on the upper slot means the lower one was jumped over
	assign first_slot_valid = ~pc[SLOT_BIT];

	// sequential successor always starts at the next word boundary
	assign seq_pc = word_addr + FETCH_BYTES;

	//////////////////////////////
	// next pc
	//////////////////////////////

	always_comb
	begin
		if (branch_taken)
		begin
			next_pc = target_pc;  // redirect wins
		end
		else if (advance)
		begin
			next_pc = seq_pc;
		end
		else
		begin
			// stalled or not selected
			next_pc = pc;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= RESET_PC;
		end
		else
		begin
			pc <= next_pc;
		end
	end

endmodule

// File: common/fetch_pkg.sv
// 64-bit addresses, two 32-bit instructions per 8-byte memory word, thread id 0 is thread 1
package fetch_pkg;

	//////////////////////////////
	// widths with a meaning
	//////////////////////////////

	typedef logic [63:0] addr_t;   // byte address of an instruction
	typedef logic [63:0] word_t;   // one memory word, two instructions
	typedef logic [31:0] inst_t;   // single instruction

	// thread id carried with every fetched pair
	typedef logic [0:0] thread_t;  // 0 is thread 1, 1 is thread 2

	//////////////////////////////
	// fetch geometry
	//////////////////////////////

	// byte offset bits inside a memory word
	localparam int OFFSET_BITS = 3;

	// address bit that picks the upper instruction of a word
	localparam int SLOT_BIT = 2;

	localparam addr_t FETCH_BYTES = 64'd8;  // stride of one fetch

	//////////////////////////////
	// thread selector
	//////////////////////////////

	// encoded so the state doubles as the thread id
	typedef enum logic [0:0]
	{
		SEL_THREAD1 = 1'b0,
		SEL_THREAD2 = 1'b1
	} thread_sel_t;

endpackage
